/* files.f */
hdl/cpu_pkg.sv
hdl/alu_unit.sv
hdl/bus_splitter.sv
hdl/data_ram.sv
hdl/acc_core.sv
hdl/cpu_subsystem.sv
verification/tb_clock.sv
verification/tb_cpu_subsystem.sv

/* hdl/acc_core.sv */
`timescale 1ns/1ns
`default_nettype none

module acc_core (
   input  wire                          clk,
   input  wire                          i_reset,
   input  cpu_pkg::mem_rsp_t            i_rsp,
   input  wire [cpu_pkg::DATA_W-1:0]    i_alu_result,
   output cpu_pkg::mem_req_t            o_req,
   output cpu_pkg::opcode_e             o_alu_op,
   output logic [cpu_pkg::DATA_W-1:0]   o_acc,
   output logic [cpu_pkg::DATA_W-1:0]   o_imm,
   output logic                         o_trace_valid,
   output cpu_pkg::trace_t              o_trace,
   output logic                         o_halted,
   output logic                         o_trap
);

   typedef enum logic [1:0] {
      S_FETCH,
      S_DECODE,
      S_DATA,
      S_HALT
   } state_e;

   state_e                      state_q;
   cpu_pkg::mem_req_t           req_q;
   cpu_pkg::instr_u             ir_q;
   cpu_pkg::instr_u             fetch_word;
   logic [cpu_pkg::ADDR_W-1:0]  pc_q;
   logic [cpu_pkg::ADDR_W-1:0]  pc_next;
   logic [cpu_pkg::DATA_W-1:0]  acc_q;
   logic [cpu_pkg::DATA_W-1:0]  acc_after;
   logic                        is_imm;

   function automatic cpu_pkg::mem_req_t fetch_at(input logic [cpu_pkg::ADDR_W-1:0] addr);
      cpu_pkg::mem_req_t req;
      req       = '0;
      req.valid = 1'b1;
      req.instr = 1'b1;
      req.addr  = addr;
      return req;
   endfunction

   // word on the bus while a fetch completes
   assign fetch_word = i_rsp.rdata;
   assign is_imm     = fetch_word.imm.op inside {cpu_pkg::OP_LDI, cpu_pkg::OP_ADDI,
                                                 cpu_pkg::OP_XORI};
   assign pc_next    = pc_q + {{(cpu_pkg::ADDR_W-3){1'b0}}, 3'd4};
   assign acc_after  = (ir_q.mem.op == cpu_pkg::OP_LD) ? i_rsp.rdata : acc_q;

   assign o_req    = req_q;
   assign o_alu_op = fetch_word.imm.op;
   assign o_acc    = acc_q;
   assign o_imm    = {{(cpu_pkg::DATA_W-28){1'b0}}, fetch_word.imm.imm};

   always_ff @(posedge clk)
   begin
      o_trace_valid <= 1'b0;
      if (i_reset)
      begin
         state_q     <= S_FETCH;
         pc_q        <= '0;
         acc_q       <= '0;
         req_q.valid <= 1'b0;
         o_halted    <= 1'b0;
         o_trap      <= 1'b0;
      end
      else
      begin
         case (state_q)
            S_FETCH:
            begin
               // first cycle out of reset raises the request
               if (!req_q.valid)
               begin
                  req_q <= fetch_at(pc_q);
               end
               else if (i_rsp.ready)
               begin
                  ir_q <= fetch_word;
                  if (is_imm)
                  begin
                     // immediates retire straight from the fetch
                     acc_q         <= i_alu_result;
                     pc_q          <= pc_next;
                     req_q         <= fetch_at(pc_next);
                     o_trace_valid <= 1'b1;
                     o_trace.pc    <= pc_q;
                     o_trace.acc   <= i_alu_result;
                  end
                  else
                  begin
                     req_q.valid <= 1'b0;
                     state_q     <= S_DECODE;
                  end
               end
            end
            S_DECODE:
            begin
               case (ir_q.mem.op)
                  cpu_pkg::OP_LD, cpu_pkg::OP_ST:
                  begin
                     req_q.valid <= 1'b1;
                     req_q.instr <= 1'b0;
                     req_q.addr  <= {{(cpu_pkg::ADDR_W-24){1'b0}}, ir_q.mem.addr[23:2], 2'b00};
                     req_q.wdata <= acc_q;
                     req_q.wstrb <= (ir_q.mem.op == cpu_pkg::OP_ST) ? ir_q.mem.strb : 4'b0000;
                     state_q     <= S_DATA;
                  end
                  cpu_pkg::OP_HLT:
                  begin
                     o_trace_valid <= 1'b1;
                     o_trace.pc    <= pc_q;
                     o_trace.acc   <= acc_q;
                     o_halted      <= 1'b1;
                     state_q       <= S_HALT;
                  end
                  default:
                  begin
                     o_trap  <= 1'b1;
                     state_q <= S_HALT;
                  end
               endcase
            end
            S_DATA:
            begin
               if (i_rsp.ready)
               begin
                  acc_q         <= acc_after;
                  o_trace_valid <= 1'b1;
                  o_trace.pc    <= pc_q;
                  o_trace.acc   <= acc_after;
                  pc_q          <= pc_next;
                  req_q         <= fetch_at(pc_next);
                  state_q       <= S_FETCH;
               end
            end
            default:
            begin
               // stopped until the next reset
               state_q <= S_HALT;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/alu_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
   input  cpu_pkg::opcode_e             i_op,
   input  wire [cpu_pkg::DATA_W-1:0]    i_acc,
   input  wire [cpu_pkg::DATA_W-1:0]    i_imm,
   output logic [cpu_pkg::DATA_W-1:0]   o_result
);

   // immediate arrives already zero extended
   always_comb
   begin
      case (i_op)
         cpu_pkg::OP_LDI:
         begin
            o_result = i_imm;
         end
         cpu_pkg::OP_ADDI:
         begin
            o_result = i_acc + i_imm;
         end
         cpu_pkg::OP_XORI:
         begin
            o_result = i_acc ^ i_imm;
         end
         default:
         begin
            // memory ops and halt leave acc alone
            o_result = i_acc;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hdl/bus_splitter.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_splitter (
   input  cpu_pkg::mem_req_t            i_req,
   input  wire                          i_i_ready,
   input  wire [cpu_pkg::DATA_W-1:0]    i_i_data,
   input  cpu_pkg::mem_rsp_t            i_d_rsp,
   output cpu_pkg::mem_rsp_t            o_rsp,
   output logic                         o_i_valid,
   output logic [cpu_pkg::ADDR_W-1:0]   o_i_addr,
   output cpu_pkg::mem_req_t            o_d_req,
   output logic                         o_halt_fetch
);

   logic i_active;

   assign i_active = i_req.valid & i_req.instr;

   assign o_i_valid = i_active;
   assign o_i_addr  = i_req.addr;

   // high whenever no fetch is outstanding
   assign o_halt_fetch = ~i_active;

   always_comb
   begin
      o_d_req       = i_req;
      o_d_req.valid = i_req.valid & ~i_req.instr;
      o_d_req.instr = 1'b0;
      if (i_req.instr)
      begin
         o_d_req.wstrb = 4'b0000;
      end
   end

   // answer comes back from whichever bus the flag picked
   always_comb
   begin
      if (i_req.instr)
      begin
         o_rsp.ready = i_i_ready;
         o_rsp.rdata = i_i_data;
      end
      else
      begin
         o_rsp.ready = i_d_rsp.ready;
         o_rsp.rdata = i_d_rsp.rdata;
      end
   end

endmodule

`default_nettype wire

/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   parameter int ADDR_W = 32;
   parameter int DATA_W = 32;

   // values not listed here trap
   typedef enum logic [3:0] {
      OP_LDI  = 4'h1,
      OP_ADDI = 4'h2,
      OP_XORI = 4'h3,
      OP_LD   = 4'h4,
      OP_ST   = 4'h5,
      OP_HLT  = 4'hf
   } opcode_e;

   typedef struct packed {
      opcode_e     op;
      logic [3:0]  strb;
      logic [23:0] addr;
   } instr_mem_t;

   typedef struct packed {
      opcode_e     op;
      logic [27:0] imm;
   } instr_imm_t;

   typedef union packed {
      instr_mem_t mem;
      instr_imm_t imm;
   } instr_u;

   // instr flag picks the route of the unified bus
   typedef struct packed {
      logic              valid;
      logic              instr;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [3:0]        wstrb;
   } mem_req_t;

   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
   } mem_rsp_t;

   typedef struct packed {
      logic [ADDR_W-1:0] pc;
      logic [DATA_W-1:0] acc;
   } trace_t;

endpackage

`default_nettype wire

/* hdl/cpu_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_subsystem #(
   parameter int RAM_WORDS = 256
) (
   input  wire                          clk,
   input  wire                          i_reset,
   input  wire                          i_i_ready,
   input  wire [cpu_pkg::DATA_W-1:0]    i_i_data,
   output logic                         o_i_valid,
   output logic [cpu_pkg::ADDR_W-1:0]   o_i_addr,
   output logic                         o_halt_fetch,
   output logic                         o_trace_valid,
   output cpu_pkg::trace_t              o_trace,
   output logic                         o_halted,
   output logic                         o_trap
);

   cpu_pkg::mem_req_t           core_req;
   cpu_pkg::mem_rsp_t           core_rsp;
   cpu_pkg::mem_req_t           d_req;
   cpu_pkg::mem_rsp_t           d_rsp;
   cpu_pkg::opcode_e            alu_op;
   logic [cpu_pkg::DATA_W-1:0]  alu_acc;
   logic [cpu_pkg::DATA_W-1:0]  alu_imm;
   logic [cpu_pkg::DATA_W-1:0]  alu_result;

   acc_core i_acc_core (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_rsp         (core_rsp),
      .i_alu_result  (alu_result),
      .o_req         (core_req),
      .o_alu_op      (alu_op),
      .o_acc         (alu_acc),
      .o_imm         (alu_imm),
      .o_trace_valid (o_trace_valid),
      .o_trace       (o_trace),
      .o_halted      (o_halted),
      .o_trap        (o_trap)
   );

   alu_unit i_alu_unit (
      .i_op     (alu_op),
      .i_acc    (alu_acc),
      .i_imm    (alu_imm),
      .o_result (alu_result)
   );

   bus_splitter i_bus_splitter (
      .i_req        (core_req),
      .i_i_ready    (i_i_ready),
      .i_i_data     (i_i_data),
      .i_d_rsp      (d_rsp),
      .o_rsp        (core_rsp),
      .o_i_valid    (o_i_valid),
      .o_i_addr     (o_i_addr),
      .o_d_req      (d_req),
      .o_halt_fetch (o_halt_fetch)
   );

   data_ram #(
      .RAM_WORDS (RAM_WORDS)
   ) i_data_ram (
      .clk     (clk),
      .i_reset (i_reset),
      .i_req   (d_req),
      .o_rsp   (d_rsp)
   );

endmodule

`default_nettype wire

/* hdl/data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
   parameter int RAM_WORDS = 256
) (
   input  wire                 clk,
   input  wire                 i_reset,
   input  cpu_pkg::mem_req_t   i_req,
   output cpu_pkg::mem_rsp_t   o_rsp
);

   localparam int IDX_W = $clog2(RAM_WORDS);

   logic [cpu_pkg::DATA_W-1:0] mem [RAM_WORDS];
   logic [cpu_pkg::DATA_W-1:0] rdata_q;
   logic [IDX_W-1:0]           idx;
   logic                       wait_q;
   logic                       start;

   // byte address wraps onto the word array
   assign idx   = i_req.addr[IDX_W+1:2];
   assign start = i_req.valid & ~wait_q;

   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         wait_q <= 1'b0;
      end
      else
      begin
         // one cycle of wait, then clear once ready is seen
         wait_q <= start;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         for (int b = 0; b < 4; b++)
         begin
            if (i_req.wstrb[b])
            begin
               mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
            end
         end
         rdata_q <= mem[idx];
      end
   end

   always_comb
   begin
      o_rsp.ready = wait_q;
      o_rsp.rdata = rdata_q;
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
   -f files.f --top-module tb_cpu_subsystem
out=$(./obj_dir/Vtb_cpu_subsystem)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Verification passed'; then
   exit 0
fi
exit 1

/* verification/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS = 4
) (
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

/* verification/tb_cpu_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_subsystem;

   localparam int RAM_WORDS       = 256;
   localparam int IDX_W           = $clog2(RAM_WORDS);
   localparam int RESET_CYCLES    = 8;
   localparam int N_IMM           = 20;
   localparam int N_SLOTS         = 6;
   // five per slot plus the closing halt
   localparam int N_MAIN          = N_IMM + 5 * N_SLOTS + 1;
   localparam int N_TRAP_IMM      = 4;
   localparam int PROG_TOTAL      = N_MAIN + N_TRAP_IMM + 1;
   localparam int WATCHDOG_CYCLES = 64 * PROG_TOTAL;

   logic              clk;
   logic              i_reset = 1'b1;
   logic              i_i_ready = 1'b0;
   logic [31:0]       i_i_data = '0;
   logic              o_i_valid;
   logic [31:0]       o_i_addr;
   logic              o_halt_fetch;
   logic              o_trace_valid;
   cpu_pkg::trace_t   o_trace;
   logic              o_halted;
   logic              o_trap;

   logic [31:0]       prog [128];
   logic [31:0]       ram_model [RAM_WORDS];
   logic [31:0]       m_pc;
   logic [31:0]       m_acc;
   logic [31:0]       cur_word;
   logic [3:0]        cur_op;
   logic [IDX_W-1:0]  ram_idx;
   logic [31:0]       exp_acc;
   logic              exp_illegal;
   logic              reset_d = 1'b0;
   logic              fetch_seen;
   int                retired;
   int                stall_left;
   int                seed;
   int                err_trace = 0;
   int                err_ctrl = 0;
   int                err_seq = 0;
   string             test_name = "reset";

   tb_clock #(.PERIOD_NS(4)) clock_gen (.clk(clk));

   cpu_subsystem #(
      .RAM_WORDS (RAM_WORDS)
   ) i_cpu_subsystem (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_i_ready     (i_i_ready),
      .i_i_data      (i_i_data),
      .o_i_valid     (o_i_valid),
      .o_i_addr      (o_i_addr),
      .o_halt_fetch  (o_halt_fetch),
      .o_trace_valid (o_trace_valid),
      .o_trace       (o_trace),
      .o_halted      (o_halted),
      .o_trap        (o_trap)
   );

   function automatic logic [31:0] encode_imm(input logic [3:0] op, input logic [27:0] imm);
      return {op, imm};
   endfunction

   function automatic logic [31:0] encode_mem(input logic [3:0] op, input logic [3:0] strb,
                                              input logic [23:0] addr);
      return {op, strb, addr};
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0] strb);
      logic [31:0] w;
      w = old_word;
      for (int b = 0; b < 4; b++)
      begin
         if (strb[b])
            w[8*b +: 8] = new_word[8*b +: 8];
      end
      return w;
   endfunction

   task automatic fill_halt();
      int i;
      for (i = 0; i < 128; i++)
         prog[i] = encode_imm(cpu_pkg::OP_HLT, 28'h0);
   endtask

   task automatic build_main_program();
      logic [31:0] r;
      logic [3:0]  op;
      logic [23:0] slot_addr [N_SLOTS];
      int          i;
      int          n;
      fill_halt();
      n = 0;
      for (i = 0; i < N_IMM; i++)
      begin
         // start from a known accumulator
         r  = (i == 0) ? 32'd0 : $urandom_range(0, 2);
         op = (r == 0) ? cpu_pkg::OP_LDI : (r == 1) ? cpu_pkg::OP_ADDI : cpu_pkg::OP_XORI;
         r  = $urandom();
         prog[n++] = encode_imm(op, r[27:0]);
      end
      // upper address bits wrap onto the RAM depth
      for (i = 0; i < N_SLOTS; i++)
      begin
         r = $urandom();
         slot_addr[i] = {r[21:0], 2'b00};
         prog[n++] = encode_imm(cpu_pkg::OP_LDI, r[31:4]);
         prog[n++] = encode_mem(cpu_pkg::OP_ST, 4'hf, slot_addr[i]);
      end
      for (i = 0; i < N_SLOTS; i++)
      begin
         r = $urandom();
         prog[n++] = encode_imm(cpu_pkg::OP_LDI, r[27:0]);
         r = $urandom_range(1, 14);
         prog[n++] = encode_mem(cpu_pkg::OP_ST, r[3:0], slot_addr[i]);
      end
      for (i = 0; i < N_SLOTS; i++)
         prog[n++] = encode_mem(cpu_pkg::OP_LD, 4'h0, slot_addr[i]);
   endtask

   task automatic build_trap_program();
      logic [31:0] r;
      logic [3:0]  op;
      int          i;
      fill_halt();
      for (i = 0; i < N_TRAP_IMM; i++)
      begin
         r  = $urandom();
         op = (i == 0) ? cpu_pkg::OP_LDI : cpu_pkg::OP_ADDI;
         prog[i] = encode_imm(op, r[27:0]);
      end
      r = $urandom_range(6, 14);
      prog[N_TRAP_IMM] = encode_imm(r[3:0], 28'h0);
   endtask

   task automatic hold_reset();
      repeat (RESET_CYCLES) @(posedge clk);
      i_reset <= 1'b0;
   endtask

   task automatic wait_retired(input int count);
      while (retired < count && !o_trap)
         @(negedge clk);
   endtask

   // instruction memory with 0 to 3 stall cycles per fetch
   always @(posedge clk)
   begin
      if (i_reset)
      begin
         i_i_ready  <= 1'b0;
         stall_left <= $urandom_range(0, 3);
      end
      else if (o_i_valid && i_i_ready)
      begin
         i_i_ready  <= 1'b0;
         stall_left <= $urandom_range(0, 3);
      end
      else if (o_i_valid)
      begin
         if (stall_left == 0)
         begin
            i_i_ready <= 1'b1;
            i_i_data  <= prog[o_i_addr[8:2]];
         end
         else
            stall_left <= stall_left - 1;
      end
   end

   // reference model of the next instruction to retire
   always_comb
   begin
      cur_word    = prog[m_pc[8:2]];
      cur_op      = cur_word[31:28];
      ram_idx     = cur_word[IDX_W+1:2];
      exp_acc     = m_acc;
      exp_illegal = 1'b0;
      case (cur_op)
         cpu_pkg::OP_LDI:  exp_acc = {4'h0, cur_word[27:0]};
         cpu_pkg::OP_ADDI: exp_acc = m_acc + {4'h0, cur_word[27:0]};
         cpu_pkg::OP_XORI: exp_acc = m_acc ^ {4'h0, cur_word[27:0]};
         cpu_pkg::OP_LD:   exp_acc = ram_model[ram_idx];
         cpu_pkg::OP_ST, cpu_pkg::OP_HLT: exp_acc = m_acc;
         default:          exp_illegal = 1'b1;
      endcase
   end

   always @(posedge clk)
   begin
      reset_d <= i_reset;
      if (i_reset)
      begin
         m_pc       <= '0;
         m_acc      <= '0;
         retired    <= 0;
         fetch_seen <= 1'b0;
      end
      else
      begin
         if (o_i_valid)
            fetch_seen <= 1'b1;
         if (o_trace_valid)
         begin
            if (cur_op == cpu_pkg::OP_ST)
               ram_model[ram_idx] <= merge_bytes(ram_model[ram_idx], m_acc, cur_word[27:24]);
            m_pc    <= m_pc + 32'd4;
            m_acc   <= exp_acc;
            retired <= retired + 1;
         end
      end
   end

   trace_pc_check: assert property (@(posedge clk) disable iff (i_reset)
         o_trace_valid |-> o_trace.pc == m_pc)
      else
      begin
         err_trace++;
         $display("error: %s trace pc expected %h actual %h", test_name,
                  $sampled(m_pc), $sampled(o_trace.pc));
      end

   trace_acc_check: assert property (@(posedge clk) disable iff (i_reset)
         o_trace_valid |-> o_trace.acc == exp_acc)
      else
      begin
         err_trace++;
         $display("error: %s trace acc expected %h actual %h", test_name,
                  $sampled(exp_acc), $sampled(o_trace.acc));
      end

   trace_legal_check: assert property (@(posedge clk) disable iff (i_reset)
         o_trace_valid |-> !exp_illegal)
      else
      begin
         err_ctrl++;
         $display("%s: an illegal instruction retired with a trace pulse", test_name);
      end

   halt_pulse_check: assert property (@(posedge clk) disable iff (i_reset)
         o_trace_valid && cur_op == cpu_pkg::OP_HLT |-> o_halted)
      else
      begin
         err_ctrl++;
         $display("%s: o_halted did not rise with the halt trace pulse", test_name);
      end

   halt_stays_check: assert property (@(posedge clk) disable iff (i_reset)
         o_halted |=> o_halted && !o_i_valid && !o_trace_valid && o_halt_fetch)
      else
      begin
         err_ctrl++;
         $display("%s: core fetched, retired or left halt after halting", test_name);
      end

   trap_quiet_check: assert property (@(posedge clk) disable iff (i_reset)
         o_trap |=> o_trap && !o_trace_valid && !o_i_valid)
      else
      begin
         err_ctrl++;
         $display("%s: core kept running or dropped o_trap after a trap", test_name);
      end

   trap_cause_check: assert property (@(posedge clk) disable iff (i_reset)
         $rose(o_trap) |-> exp_illegal && !o_trace_valid)
      else
      begin
         err_ctrl++;
         $display("%s: o_trap rose without an illegal opcode or with a trace", test_name);
      end

   reset_state_check: assert property (@(posedge clk)
         reset_d |-> !o_i_valid && !o_trace_valid && !o_trap && !o_halted)
      else
      begin
         err_ctrl++;
         $display("%s: outputs not low during or right after reset", test_name);
      end

   first_fetch_check: assert property (@(posedge clk) disable iff (i_reset)
         o_i_valid && !fetch_seen |-> o_i_addr == 32'h0)
      else
      begin
         err_ctrl++;
         $display("error: %s first fetch address expected %h actual %h", test_name,
                  32'h0, $sampled(o_i_addr));
      end

   fetch_hold_check: assert property (@(posedge clk) disable iff (i_reset)
         o_i_valid && !i_i_ready |=> o_i_valid && $stable(o_i_addr))
      else
      begin
         err_ctrl++;
         $display("%s: fetch request changed while the memory stalled", test_name);
      end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("errors: trace %0d control %0d sequence %0d", err_trace, err_ctrl, err_seq);
      $display("Verification failed");
      $finish;
   end

   initial
   begin
      seed = $urandom(32'hebf3);
      build_main_program();
      hold_reset();
      test_name = "imm_arith";
      wait_retired(N_IMM);
      test_name = "store_load";
      wait_retired(N_MAIN - 1);
      test_name = "halt";
      wait_retired(N_MAIN);
      halt_seen: assert (o_halted)
      else
      begin
         err_seq++;
         $display("%s: core never raised o_halted", test_name);
      end
      repeat (40) @(negedge clk);
      main_count: assert (retired == N_MAIN)
      else
      begin
         err_seq++;
         $display("error: %s retired count expected %0d actual %0d", test_name, N_MAIN, retired);
      end

      // second run out of a fresh reset
      test_name = "trap";
      @(posedge clk);
      i_reset <= 1'b1;
      build_trap_program();
      hold_reset();
      while (!o_trap)
         @(negedge clk);
      repeat (40) @(negedge clk);
      trap_count: assert (retired == N_TRAP_IMM)
      else
      begin
         err_seq++;
         $display("error: %s retired count expected %0d actual %0d", test_name, N_TRAP_IMM,
                  retired);
      end

      $display("errors: trace %0d control %0d sequence %0d", err_trace, err_ctrl, err_seq);
      if (err_trace + err_ctrl + err_seq == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire
